// ==== src/video_out_pkg.sv ====
/*
 * Shared widths and constants for the pclk_out video output stage.
 * Palette words are packed RGB with red in the top byte.
 * Extra-output mode codes match the 2-bit mode register of the board.
 */

package video_out_pkg;

    // Channel and control widths
    localparam int COLOR_W     = 8;
    localparam int OSD_COLOR_W = 2;
    localparam int MODE_W      = 2;

    // OSD palette indexed by osd_color code 0 to 3
    localparam logic [3*COLOR_W-1:0] OSD_BLACK  = 24'h000000;
    localparam logic [3*COLOR_W-1:0] OSD_BLUE   = 24'h0000ff;
    localparam logic [3*COLOR_W-1:0] OSD_YELLOW = 24'hffff00;
    localparam logic [3*COLOR_W-1:0] OSD_WHITE  = 24'hffffff;

    // Extra analog output modes
    // RGBHV with separate hsync and vsync
    localparam logic [MODE_W-1:0] EXTRA_OUT_RGBHV = 2'd0;
    // RGBCS with composite sync on the hsync line
    localparam logic [MODE_W-1:0] EXTRA_OUT_RGBCS = 2'd1;
    // RGsB with composite sync also on green through sync_n
    localparam logic [MODE_W-1:0] EXTRA_OUT_RGSB  = 2'd2;
    // YPbPr with sync on luma and blanking left to the encoder
    localparam logic [MODE_W-1:0] EXTRA_OUT_YPBPR = 2'd3;

endpackage

// ==== src/osd_overlay.sv ====
/*
 * First output register stage. Replaces the pixel with a fixed OSD
 * palette color while osd_enable_i is high. Syncs and DE are delayed
 * by the same single cycle. osd_color_i must be known when enabled.
 */

`timescale 1ns/1ps

module osd_overlay (
    input  logic                                pclk_out,
    input  logic                                po_reset_n,
    input  logic [video_out_pkg::COLOR_W-1:0]   r_i,
    input  logic [video_out_pkg::COLOR_W-1:0]   g_i,
    input  logic [video_out_pkg::COLOR_W-1:0]   b_i,
    input  logic                                hsync_i,
    input  logic                                vsync_i,
    input  logic                                de_i,
    input  logic                                osd_enable_i,
    input  logic [video_out_pkg::OSD_COLOR_W-1:0] osd_color_i,
    output logic [video_out_pkg::COLOR_W-1:0]   r_o,
    output logic [video_out_pkg::COLOR_W-1:0]   g_o,
    output logic [video_out_pkg::COLOR_W-1:0]   b_o,
    output logic                                hsync_o,
    output logic                                vsync_o,
    output logic                                de_o
);

    import video_out_pkg::*;

    logic [3*COLOR_W-1:0] osd_rgb;
    logic [3*COLOR_W-1:0] pix_rgb;

    // Palette lookup
    always_comb begin
        case (osd_color_i)
            2'd0:    osd_rgb = OSD_BLACK;
            2'd1:    osd_rgb = OSD_BLUE;
            2'd2:    osd_rgb = OSD_YELLOW;
            default: osd_rgb = OSD_WHITE;
        endcase
    end

    assign pix_rgb = osd_enable_i ? osd_rgb : {r_i, g_i, b_i};

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            {r_o, g_o, b_o} <= '0;
            hsync_o         <= 1'b0;
            vsync_o         <= 1'b0;
            de_o            <= 1'b0;
        end else begin
            {r_o, g_o, b_o} <= pix_rgb;
            hsync_o         <= hsync_i;
            vsync_o         <= vsync_i;
            de_o            <= de_i;
        end
    end

    // OSD generator must deliver a valid code whenever it overlays
    a_osd_color_known: assert property (
        @(posedge pclk_out) disable iff (!po_reset_n)
        osd_enable_i |-> !$isunknown(osd_color_i)
    ) else $error("osd_color_i unknown while OSD enabled");

endmodule

// ==== src/dac_sync_encoder.sv ====
/*
 * Registered sync and blank encoding for the analog DAC.
 * Composite sync is ~(hsync ^ vsync) of the raw input syncs.
 * Modes without a separate vsync line drive it high.
 * One cycle latency, aligned with the OSD overlay stage.
 */

`timescale 1ns/1ps

module dac_sync_encoder (
    input  logic                            pclk_out,
    input  logic                            po_reset_n,
    input  logic                            hsync_i,
    input  logic                            vsync_i,
    input  logic                            de_i,
    input  logic [video_out_pkg::MODE_W-1:0] extra_out_mode_i,
    output logic                            hsync_o,
    output logic                            vsync_o,
    output logic                            blank_n_o,
    output logic                            sync_n_o
);

    import video_out_pkg::*;

    logic csync;
    logic hsync_nxt;
    logic vsync_nxt;
    logic blank_n_nxt;
    logic sync_n_nxt;

    assign csync = ~(hsync_i ^ vsync_i);

    always_comb begin
        hsync_nxt   = csync;
        vsync_nxt   = 1'b1;
        blank_n_nxt = de_i;
        sync_n_nxt  = 1'b0;
        case (extra_out_mode_i)
            EXTRA_OUT_RGBHV: begin
                hsync_nxt = hsync_i;
                vsync_nxt = vsync_i;
            end
            EXTRA_OUT_RGBCS: begin
                sync_n_nxt = 1'b0;
            end
            EXTRA_OUT_RGSB: begin
                sync_n_nxt = csync;
            end
            EXTRA_OUT_YPBPR: begin
                // Blanking comes from the video level itself
                blank_n_nxt = 1'b1;
                sync_n_nxt  = csync;
            end
            default: begin
                sync_n_nxt = 1'b0;
            end
        endcase
    end

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            hsync_o   <= 1'b0;
            vsync_o   <= 1'b0;
            blank_n_o <= 1'b0;
            sync_n_o  <= 1'b0;
        end else begin
            hsync_o   <= hsync_nxt;
            vsync_o   <= vsync_nxt;
            blank_n_o <= blank_n_nxt;
            sync_n_o  <= sync_n_nxt;
        end
    end

    // No sync on green in RGB modes with separate sync
    a_rgb_no_sog: assert property (
        @(posedge pclk_out) disable iff (!po_reset_n)
        (extra_out_mode_i == EXTRA_OUT_RGBHV || extra_out_mode_i == EXTRA_OUT_RGBCS)
            |=> !sync_n_o
    ) else $error("sync_n_o high in RGBHV/RGBCS mode");

    a_ypbpr_no_blank: assert property (
        @(posedge pclk_out) disable iff (!po_reset_n)
        (extra_out_mode_i == EXTRA_OUT_YPBPR) |=> blank_n_o
    ) else $error("blank_n_o low in YPbPr mode");

endmodule

// ==== src/tx_dac_output.sv ====
/*
 * Final output registers. The HDMI transmitter side follows the
 * overlay stage on every edge. The DAC side loads only while the
 * delayed extra-output enable is high and holds its last values
 * otherwise. extra_out_en_i reaches dac_en_o after two cycles.
 */

`timescale 1ns/1ps

module tx_dac_output (
    input  logic                              pclk_out,
    input  logic                              po_reset_n,
    input  logic [video_out_pkg::COLOR_W-1:0] ov_r_i,
    input  logic [video_out_pkg::COLOR_W-1:0] ov_g_i,
    input  logic [video_out_pkg::COLOR_W-1:0] ov_b_i,
    input  logic                              ov_hsync_i,
    input  logic                              ov_vsync_i,
    input  logic                              ov_de_i,
    input  logic                              enc_hsync_i,
    input  logic                              enc_vsync_i,
    input  logic                              enc_blank_n_i,
    input  logic                              enc_sync_n_i,
    input  logic                              extra_out_en_i,
    output logic [video_out_pkg::COLOR_W-1:0] tx_r_o,
    output logic [video_out_pkg::COLOR_W-1:0] tx_g_o,
    output logic [video_out_pkg::COLOR_W-1:0] tx_b_o,
    output logic                              tx_hsync_o,
    output logic                              tx_vsync_o,
    output logic                              tx_de_o,
    output logic [video_out_pkg::COLOR_W-1:0] dac_r_o,
    output logic [video_out_pkg::COLOR_W-1:0] dac_g_o,
    output logic [video_out_pkg::COLOR_W-1:0] dac_b_o,
    output logic                              dac_hsync_o,
    output logic                              dac_vsync_o,
    output logic                              dac_blank_n_o,
    output logic                              dac_sync_n_o,
    output logic                              dac_en_o
);

    // Enable aligned with the stage-1 data
    logic extra_out_en_q;

    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            extra_out_en_q <= 1'b0;
            dac_en_o       <= 1'b0;
        end else begin
            extra_out_en_q <= extra_out_en_i;
            dac_en_o       <= extra_out_en_q;
        end
    end

    // HDMI TX
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            {tx_r_o, tx_g_o, tx_b_o} <= '0;
            tx_hsync_o               <= 1'b0;
            tx_vsync_o               <= 1'b0;
            tx_de_o                  <= 1'b0;
        end else begin
            {tx_r_o, tx_g_o, tx_b_o} <= {ov_r_i, ov_g_i, ov_b_i};
            tx_hsync_o               <= ov_hsync_i;
            tx_vsync_o               <= ov_vsync_i;
            tx_de_o                  <= ov_de_i;
        end
    end

    // Analog DAC holds while the expansion port is used otherwise
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            {dac_r_o, dac_g_o, dac_b_o} <= '0;
            dac_hsync_o                 <= 1'b0;
            dac_vsync_o                 <= 1'b0;
            dac_blank_n_o               <= 1'b0;
            dac_sync_n_o                <= 1'b0;
        end else if (extra_out_en_q) begin
            {dac_r_o, dac_g_o, dac_b_o} <= {ov_r_i, ov_g_i, ov_b_i};
            dac_hsync_o                 <= enc_hsync_i;
            dac_vsync_o                 <= enc_vsync_i;
            dac_blank_n_o               <= enc_blank_n_i;
            dac_sync_n_o                <= enc_sync_n_i;
        end
    end

    // dac_en_o low means no load happened on the last edge
    a_dac_hold: assert property (
        @(posedge pclk_out) disable iff (!po_reset_n)
        !dac_en_o |-> $stable({dac_r_o, dac_g_o, dac_b_o, dac_hsync_o, dac_vsync_o,
                               dac_blank_n_o, dac_sync_n_o})
    ) else $error("DAC outputs changed while dac_en_o low");

endmodule

// ==== src/video_out_top.sv ====
/*
 * pclk_out output stage of the scan converter.
 * Inputs are scaled video in the pclk_out domain. Two cycles from any
 * pixel or control input to the tx_* and dac_* outputs.
 * DAC pixels are sent unconverted in every extra-output mode.
 */

`timescale 1ns/1ps

module video_out_top (
    input  logic                                  pclk_out,
    input  logic                                  po_reset_n,
    input  logic [video_out_pkg::COLOR_W-1:0]     r_i,
    input  logic [video_out_pkg::COLOR_W-1:0]     g_i,
    input  logic [video_out_pkg::COLOR_W-1:0]     b_i,
    input  logic                                  hsync_i,
    input  logic                                  vsync_i,
    input  logic                                  de_i,
    input  logic                                  osd_enable_i,
    input  logic [video_out_pkg::OSD_COLOR_W-1:0] osd_color_i,
    input  logic                                  extra_out_en_i,
    input  logic [video_out_pkg::MODE_W-1:0]      extra_out_mode_i,
    output logic [video_out_pkg::COLOR_W-1:0]     tx_r_o,
    output logic [video_out_pkg::COLOR_W-1:0]     tx_g_o,
    output logic [video_out_pkg::COLOR_W-1:0]     tx_b_o,
    output logic                                  tx_hsync_o,
    output logic                                  tx_vsync_o,
    output logic                                  tx_de_o,
    output logic [video_out_pkg::COLOR_W-1:0]     dac_r_o,
    output logic [video_out_pkg::COLOR_W-1:0]     dac_g_o,
    output logic [video_out_pkg::COLOR_W-1:0]     dac_b_o,
    output logic                                  dac_hsync_o,
    output logic                                  dac_vsync_o,
    output logic                                  dac_blank_n_o,
    output logic                                  dac_sync_n_o,
    output logic                                  dac_en_o
);

    import video_out_pkg::*;

    // Stage 1 overlay outputs
    logic [COLOR_W-1:0] ov_r;
    logic [COLOR_W-1:0] ov_g;
    logic [COLOR_W-1:0] ov_b;
    logic               ov_hsync;
    logic               ov_vsync;
    logic               ov_de;

    // Stage 1 sync encoder outputs
    logic enc_hsync;
    logic enc_vsync;
    logic enc_blank_n;
    logic enc_sync_n;

    osd_overlay u_osd_overlay (
        .pclk_out     (pclk_out),
        .po_reset_n   (po_reset_n),
        .r_i          (r_i),
        .g_i          (g_i),
        .b_i          (b_i),
        .hsync_i      (hsync_i),
        .vsync_i      (vsync_i),
        .de_i         (de_i),
        .osd_enable_i (osd_enable_i),
        .osd_color_i  (osd_color_i),
        .r_o          (ov_r),
        .g_o          (ov_g),
        .b_o          (ov_b),
        .hsync_o      (ov_hsync),
        .vsync_o      (ov_vsync),
        .de_o         (ov_de)
    );

    dac_sync_encoder u_dac_sync_encoder (
        .pclk_out         (pclk_out),
        .po_reset_n       (po_reset_n),
        .hsync_i          (hsync_i),
        .vsync_i          (vsync_i),
        .de_i             (de_i),
        .extra_out_mode_i (extra_out_mode_i),
        .hsync_o          (enc_hsync),
        .vsync_o          (enc_vsync),
        .blank_n_o        (enc_blank_n),
        .sync_n_o         (enc_sync_n)
    );

    tx_dac_output u_tx_dac_output (
        .pclk_out       (pclk_out),
        .po_reset_n     (po_reset_n),
        .ov_r_i         (ov_r),
        .ov_g_i         (ov_g),
        .ov_b_i         (ov_b),
        .ov_hsync_i     (ov_hsync),
        .ov_vsync_i     (ov_vsync),
        .ov_de_i        (ov_de),
        .enc_hsync_i    (enc_hsync),
        .enc_vsync_i    (enc_vsync),
        .enc_blank_n_i  (enc_blank_n),
        .enc_sync_n_i   (enc_sync_n),
        .extra_out_en_i (extra_out_en_i),
        .tx_r_o         (tx_r_o),
        .tx_g_o         (tx_g_o),
        .tx_b_o         (tx_b_o),
        .tx_hsync_o     (tx_hsync_o),
        .tx_vsync_o     (tx_vsync_o),
        .tx_de_o        (tx_de_o),
        .dac_r_o        (dac_r_o),
        .dac_g_o        (dac_g_o),
        .dac_b_o        (dac_b_o),
        .dac_hsync_o    (dac_hsync_o),
        .dac_vsync_o    (dac_vsync_o),
        .dac_blank_n_o  (dac_blank_n_o),
        .dac_sync_n_o   (dac_sync_n_o),
        .dac_en_o       (dac_en_o)
    );

endmodule

// ==== sim/tb_video_out_top.sv ====
/*
 * Directed testbench for video_out_top.
 * Outputs are compared two pclk_out cycles after the inputs were driven.
 * A DAC model holds the last loaded values while the enable is low.
 * Random pixels come from $random with a fixed seed.
 */

`timescale 1ns/1ps

module tb_video_out_top;

    localparam int CLK_PERIOD_NS = 20;
    localparam int RST_CYCLES    = 16;
    localparam int PASS_PIXELS   = 64;
    localparam int OSD_PIXELS    = 16;
    localparam int MODE_COMBOS   = 4 * 8;
    localparam int HOLD_PIXELS   = 24;
    localparam int FLUSH_CYCLES  = 2;
    localparam int TOTAL_CYCLES  = RST_CYCLES + PASS_PIXELS + 4 * OSD_PIXELS + MODE_COMBOS
                                   + HOLD_PIXELS + 5 * FLUSH_CYCLES;
    localparam int WATCHDOG_NS   = 2 * TOTAL_CYCLES * CLK_PERIOD_NS;

    logic       pclk_out = 1'b0;
    logic       po_reset_n;
    logic [7:0] r_i;
    logic [7:0] g_i;
    logic [7:0] b_i;
    logic       hsync_i;
    logic       vsync_i;
    logic       de_i;
    logic       osd_enable_i;
    logic [1:0] osd_color_i;
    logic       extra_out_en_i;
    logic [1:0] extra_out_mode_i;
    logic [7:0] tx_r_o;
    logic [7:0] tx_g_o;
    logic [7:0] tx_b_o;
    logic       tx_hsync_o;
    logic       tx_vsync_o;
    logic       tx_de_o;
    logic [7:0] dac_r_o;
    logic [7:0] dac_g_o;
    logic [7:0] dac_b_o;
    logic       dac_hsync_o;
    logic       dac_vsync_o;
    logic       dac_blank_n_o;
    logic       dac_sync_n_o;
    logic       dac_en_o;

    // Expected values in flight with one entry per driven cycle
    logic [26:0] tx_q[$];
    logic [27:0] dac_q[$];
    logic        en_q[$];
    logic [27:0] dac_model;
    logic [31:0] rnd;
    integer      seed;
    string       test_name;
    int          test_errors;
    int          tests_passed;
    int          tests_failed;

    always #(CLK_PERIOD_NS / 2) pclk_out = ~pclk_out;

    video_out_top i_dut (
        .pclk_out         (pclk_out),
        .po_reset_n       (po_reset_n),
        .r_i              (r_i),
        .g_i              (g_i),
        .b_i              (b_i),
        .hsync_i          (hsync_i),
        .vsync_i          (vsync_i),
        .de_i             (de_i),
        .osd_enable_i     (osd_enable_i),
        .osd_color_i      (osd_color_i),
        .extra_out_en_i   (extra_out_en_i),
        .extra_out_mode_i (extra_out_mode_i),
        .tx_r_o           (tx_r_o),
        .tx_g_o           (tx_g_o),
        .tx_b_o           (tx_b_o),
        .tx_hsync_o       (tx_hsync_o),
        .tx_vsync_o       (tx_vsync_o),
        .tx_de_o          (tx_de_o),
        .dac_r_o          (dac_r_o),
        .dac_g_o          (dac_g_o),
        .dac_b_o          (dac_b_o),
        .dac_hsync_o      (dac_hsync_o),
        .dac_vsync_o      (dac_vsync_o),
        .dac_blank_n_o    (dac_blank_n_o),
        .dac_sync_n_o     (dac_sync_n_o),
        .dac_en_o         (dac_en_o)
    );

    function automatic logic [23:0] palette_word(input logic [1:0] code);
        case (code)
            2'd0:    palette_word = 24'h000000;
            2'd1:    palette_word = 24'h0000ff;
            2'd2:    palette_word = 24'hffff00;
            default: palette_word = 24'hffffff;
        endcase
    endfunction

    // Returns {hsync line, vsync line, blank_n, sync_n}
    function automatic logic [3:0] encode_syncs(input logic [1:0] mode,
                                                input logic hs, input logic vs,
                                                input logic de);
        logic cs;
        cs = ~(hs ^ vs);
        case (mode)
            2'd0:    encode_syncs = {hs, vs, de, 1'b0};
            2'd1:    encode_syncs = {cs, 1'b1, de, 1'b0};
            2'd2:    encode_syncs = {cs, 1'b1, de, cs};
            default: encode_syncs = {cs, 1'b1, 1'b1, cs};
        endcase
    endfunction

    task automatic apply_inputs(input logic [7:0] r, input logic [7:0] g,
                                input logic [7:0] b, input logic hs, input logic vs,
                                input logic de, input logic osd_en,
                                input logic [1:0] osd_col, input logic en,
                                input logic [1:0] mode);
        r_i              = r;
        g_i              = g;
        b_i              = b;
        hsync_i          = hs;
        vsync_i          = vs;
        de_i             = de;
        osd_enable_i     = osd_en;
        osd_color_i      = osd_col;
        extra_out_en_i   = en;
        extra_out_mode_i = mode;
    endtask

    task automatic compare_outputs();
        logic [26:0] exp_tx;
        logic [27:0] exp_dac;
        logic        exp_en;
        logic [26:0] act_tx;
        logic [27:0] act_dac;
        if (tx_q.size() == 2) begin
            exp_tx  = tx_q.pop_front();
            exp_dac = dac_q.pop_front();
            exp_en  = en_q.pop_front();
            act_tx  = {tx_r_o, tx_g_o, tx_b_o, tx_hsync_o, tx_vsync_o, tx_de_o};
            act_dac = {dac_r_o, dac_g_o, dac_b_o, dac_hsync_o, dac_vsync_o,
                       dac_blank_n_o, dac_sync_n_o};
            assert (act_tx === exp_tx) else begin
                $display("CHECK FAILED %s tx: expected %h actual %h", test_name, exp_tx, act_tx);
                test_errors++;
            end
            assert (act_dac === exp_dac) else begin
                $display("CHECK FAILED %s dac: expected %h actual %h",
                         test_name, exp_dac, act_dac);
                test_errors++;
            end
            assert (dac_en_o === exp_en) else begin
                $display("CHECK FAILED %s dac_en: expected %b actual %b",
                         test_name, exp_en, dac_en_o);
                test_errors++;
            end
        end
    endtask

    // Checks the pipeline output and then drives the next pixel
    task automatic drive_step(input logic [7:0] r, input logic [7:0] g,
                              input logic [7:0] b, input logic hs, input logic vs,
                              input logic de, input logic osd_en,
                              input logic [1:0] osd_col, input logic en,
                              input logic [1:0] mode);
        logic [23:0] pix;
        @(posedge pclk_out);
        #1;
        compare_outputs();
        #1;
        apply_inputs(r, g, b, hs, vs, de, osd_en, osd_col, en, mode);
        pix = osd_en ? palette_word(osd_col) : {r, g, b};
        if (en) begin
            dac_model = {pix, encode_syncs(mode, hs, vs, de)};
        end
        tx_q.push_back({pix, hs, vs, de});
        dac_q.push_back(dac_model);
        en_q.push_back(en);
    endtask

    task automatic flush_pipeline();
        for (int i = 0; i < FLUSH_CYCLES; i++) begin
            drive_step(8'h00, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 1'b0, 2'd0);
        end
    endtask

    task automatic end_test();
        flush_pipeline();
        if (test_errors == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        $display("%-16s %s, %0d errors", test_name, (test_errors == 0) ? "ok" : "FAILED",
                 test_errors);
    endtask

    task automatic expect_reset_outputs();
        logic [55:0] actual;
        actual = {tx_r_o, tx_g_o, tx_b_o, tx_hsync_o, tx_vsync_o, tx_de_o,
                  dac_r_o, dac_g_o, dac_b_o, dac_hsync_o, dac_vsync_o, dac_blank_n_o,
                  dac_sync_n_o, dac_en_o};
        assert (actual === 56'h0) else begin
            $display("CHECK FAILED %s outputs: expected %h actual %h", test_name, 56'h0, actual);
            test_errors++;
        end
    endtask

    task automatic reset_state();
        test_name   = "reset_state";
        test_errors = 0;
        // Busy inputs while in reset must not reach any output
        for (int i = 0; i < RST_CYCLES - 1; i++) begin
            @(posedge pclk_out);
            #1;
            expect_reset_outputs();
            #1;
            rnd = $random(seed);
            apply_inputs(rnd[7:0], rnd[15:8], rnd[23:16], rnd[24], rnd[25], 1'b1,
                         rnd[26], rnd[28:27], 1'b1, rnd[30:29]);
        end
        @(posedge pclk_out);
        #1;
        expect_reset_outputs();
        #1;
        po_reset_n = 1'b1;
        apply_inputs(8'h00, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 1'b0, 2'd0);
        // First edge after release still shows the reset values
        tx_q.push_back('0);
        dac_q.push_back('0);
        en_q.push_back(1'b0);
        tx_q.push_back('0);
        dac_q.push_back(dac_model);
        en_q.push_back(1'b0);
        end_test();
    endtask

    task automatic passthrough();
        test_name   = "passthrough";
        test_errors = 0;
        for (int i = 0; i < PASS_PIXELS; i++) begin
            rnd = $random(seed);
            drive_step(rnd[7:0], rnd[15:8], rnd[23:16], rnd[24], rnd[25], rnd[26],
                       1'b0, rnd[28:27], 1'b1, 2'd0);
        end
        end_test();
    endtask

    task automatic osd_palette();
        test_name   = "osd_palette";
        test_errors = 0;
        for (int c = 0; c < 4; c++) begin
            for (int i = 0; i < OSD_PIXELS; i++) begin
                rnd = $random(seed);
                drive_step(rnd[7:0], rnd[15:8], rnd[23:16], rnd[24], rnd[25], rnd[26],
                           1'b1, c[1:0], 1'b0, 2'd0);
            end
        end
        end_test();
    endtask

    task automatic dac_modes();
        test_name   = "dac_modes";
        test_errors = 0;
        for (int m = 0; m < 4; m++) begin
            for (int c = 0; c < 8; c++) begin
                rnd = $random(seed);
                drive_step(rnd[7:0], rnd[15:8], rnd[23:16], c[2], c[1], c[0],
                           rnd[24], rnd[26:25], 1'b1, m[1:0]);
            end
        end
        end_test();
    endtask

    task automatic enable_hold();
        logic en;
        test_name   = "enable_hold";
        test_errors = 0;
        for (int i = 0; i < HOLD_PIXELS; i++) begin
            // Loads for 4 pixels, holds for 12, then loads again
            en  = (i < 4) || (i >= 16);
            rnd = $random(seed);
            drive_step(rnd[7:0], rnd[15:8], rnd[23:16], rnd[24], rnd[25], rnd[26],
                       1'b0, 2'd0, en, 2'd2);
        end
        end_test();
    endtask

    initial begin
        po_reset_n = 1'b0;
        apply_inputs(8'h00, 8'h00, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0, 2'd0, 1'b0, 2'd0);
        seed         = 32'hae05;
        dac_model    = '0;
        tests_passed = 0;
        tests_failed = 0;
        reset_state();
        passthrough();
        osd_palette();
        dac_modes();
        enable_hold();
        $display("Summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== video_out_top.f ====
src/video_out_pkg.sv
src/osd_overlay.sv
src/dac_sync_encoder.sv
src/tx_dac_output.sv
src/video_out_top.sv
sim/tb_video_out_top.sv

// ==== Makefile ====
TOP := tb_video_out_top

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f video_out_top.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

.PHONY: sim clean
